// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN    = 32;
    localparam int IMEM_AW = 14;
    localparam int DMEM_AW = 14;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // selects sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_LUI, ALU_LINK,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_NOP
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_pc;
        logic    use_imm;
        logic    jal;
        logic    jalr;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
    } exec_ctrl_t;

    localparam exec_ctrl_t CTRL_BUBBLE = '{alu_op: ALU_NOP, default: 1'b0};

endpackage

`default_nettype wire

// ==== rv_core_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// decode/execute pipeline register
interface rv_issue_if (
    input logic clk,
    input logic rst
);

    rv_core_pkg::word_t      pc;
    rv_core_pkg::word_t      imm;
    rv_core_pkg::reg_addr_t  rs1;
    rv_core_pkg::reg_addr_t  rs2;
    rv_core_pkg::reg_addr_t  rd;
    rv_core_pkg::word_t      rs1_data;
    rv_core_pkg::word_t      rs2_data;
    rv_core_pkg::exec_ctrl_t ctrl;

    modport issue_src (
        output pc, imm, rs1, rs2, rd, rs1_data, rs2_data, ctrl
    );

    modport issue_dst (
        input clk, rst, pc, imm, rs1, rs2, rd, rs1_data, rs2_data, ctrl
    );

endinterface

// results of the memory and writeback stages
interface rv_fwd_if;

    rv_core_pkg::reg_addr_t mem_rd;
    logic                   mem_reg_write;
    rv_core_pkg::word_t     mem_value;
    rv_core_pkg::reg_addr_t wb_rd;
    logic                   wb_en;
    rv_core_pkg::word_t     wb_data;

    modport fwd_src (
        output mem_rd, mem_reg_write, mem_value, wb_rd, wb_en, wb_data
    );

    modport fwd_exe (
        input mem_rd, mem_reg_write, mem_value, wb_rd, wb_en, wb_data
    );

    // decode only needs the register write port
    modport fwd_dec (
        input wb_rd, wb_en, wb_data
    );

endinterface

`default_nettype wire

// ==== rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_fetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            flush,
    input  rv_core_pkg::word_t              target,
    output logic [rv_core_pkg::IMEM_AW-1:0] im_addr,
    input  rv_core_pkg::word_t              im_rdata,
    output rv_core_pkg::word_t              dec_pc,
    output rv_core_pkg::word_t              dec_insn
);

    logic               rst_dly;
    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t next_pc;

    // first fetch after reset comes from address 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_dly <= 1'b1;
        end else begin
            rst_dly <= 1'b0;
        end
    end

    always_comb begin
        if (rst_dly) begin
            next_pc = '0;
        end else if (flush) begin
            next_pc = target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign im_addr = next_pc[rv_core_pkg::IMEM_AW+1:2];

    // word returns one cycle after its address, pc still matches it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_pc   <= '0;
            dec_insn <= '0;
        end else if (rst_dly || flush) begin
            dec_pc   <= '0;
            dec_insn <= '0;
        end else if (!stall) begin
            dec_pc   <= pc;
            dec_insn <= im_rdata;
        end
    end

    a_target_aligned: assert property (
        @(posedge clk) disable iff (rst) flush |-> target[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  logic               clk,
    input  logic               rst,
    input  rv_core_pkg::word_t dec_pc,
    input  rv_core_pkg::word_t dec_insn,
    input  logic               flush,
    output logic               stall,
    rv_fwd_if.fwd_dec          fwd,
    rv_issue_if.issue_src      iss
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    rv_core_pkg::reg_addr_t  rs1;
    rv_core_pkg::reg_addr_t  rs2;
    rv_core_pkg::reg_addr_t  rd;
    rv_core_pkg::word_t      imm;
    rv_core_pkg::alu_op_t    alu_fn;
    rv_core_pkg::exec_ctrl_t ctrl;
    rv_core_pkg::word_t      rf [32];
    rv_core_pkg::word_t      rs1_data;
    rv_core_pkg::word_t      rs2_data;

    assign opcode = dec_insn[6:0];
    assign rd     = dec_insn[11:7];
    assign funct3 = dec_insn[14:12];
    assign rs1    = dec_insn[19:15];
    assign rs2    = dec_insn[24:20];
    assign funct7 = dec_insn[31:25];

    always_comb begin
        case (opcode)
            rv_core_pkg::OP_IMM, rv_core_pkg::OP_LOAD, rv_core_pkg::OP_JALR: begin
                imm = {{20{dec_insn[31]}}, dec_insn[31:20]};
            end
            rv_core_pkg::OP_STORE: begin
                imm = {{20{dec_insn[31]}}, dec_insn[31:25], dec_insn[11:7]};
            end
            rv_core_pkg::OP_BRANCH: begin
                imm = {{20{dec_insn[31]}}, dec_insn[7], dec_insn[30:25],
                       dec_insn[11:8], 1'b0};
            end
            rv_core_pkg::OP_LUI, rv_core_pkg::OP_AUIPC: begin
                imm = {dec_insn[31:12], 12'd0};
            end
            rv_core_pkg::OP_JAL: begin
                imm = {{12{dec_insn[31]}}, dec_insn[19:12], dec_insn[20],
                       dec_insn[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

    // funct3 map for the register and immediate forms
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == rv_core_pkg::OP_REG && funct7 == rv_core_pkg::F7_ALT) begin
                    alu_fn = rv_core_pkg::ALU_SUB;
                end else begin
                    alu_fn = rv_core_pkg::ALU_ADD;
                end
            end
            3'b001: alu_fn = rv_core_pkg::ALU_SLL;
            3'b010: alu_fn = rv_core_pkg::ALU_SLT;
            3'b011: alu_fn = rv_core_pkg::ALU_SLTU;
            3'b100: alu_fn = rv_core_pkg::ALU_XOR;
            3'b101: begin
                if (funct7 == rv_core_pkg::F7_ALT) begin
                    alu_fn = rv_core_pkg::ALU_SRA;
                end else begin
                    alu_fn = rv_core_pkg::ALU_SRL;
                end
            end
            3'b110: alu_fn = rv_core_pkg::ALU_OR;
            default: alu_fn = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = rv_core_pkg::CTRL_BUBBLE;
        case (opcode)
            rv_core_pkg::OP_LUI: begin
                ctrl.alu_op    = rv_core_pkg::ALU_LUI;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_AUIPC: begin
                ctrl.alu_op    = rv_core_pkg::ALU_ADD;
                ctrl.use_pc    = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_JAL: begin
                ctrl.alu_op    = rv_core_pkg::ALU_LINK;
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_JALR: begin
                ctrl.alu_op    = rv_core_pkg::ALU_LINK;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_BRANCH: begin
                case (funct3)
                    3'b000: ctrl.alu_op = rv_core_pkg::ALU_BEQ;
                    3'b001: ctrl.alu_op = rv_core_pkg::ALU_BNE;
                    3'b100: ctrl.alu_op = rv_core_pkg::ALU_BLT;
                    3'b101: ctrl.alu_op = rv_core_pkg::ALU_BGE;
                    3'b110: ctrl.alu_op = rv_core_pkg::ALU_BLTU;
                    3'b111: ctrl.alu_op = rv_core_pkg::ALU_BGEU;
                    default: ctrl.alu_op = rv_core_pkg::ALU_NOP;
                endcase
            end
            rv_core_pkg::OP_IMM: begin
                ctrl.alu_op    = alu_fn;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_REG: begin
                ctrl.alu_op    = alu_fn;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_LOAD: begin
                ctrl.alu_op    = rv_core_pkg::ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OP_STORE: begin
                ctrl.alu_op    = rv_core_pkg::ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ;
        endcase
        if (rd == '0) ctrl.reg_write = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (fwd.wb_en) rf[fwd.wb_rd] <= fwd.wb_data;
    end

    // x0 reads zero and a same-cycle write bypasses the array
    function automatic rv_core_pkg::word_t rf_read(input rv_core_pkg::reg_addr_t addr);
        if (addr == '0) return '0;
        if (fwd.wb_en && fwd.wb_rd == addr) return fwd.wb_data;
        return rf[addr];
    endfunction

    always_comb begin
        rs1_data = rf_read(rs1);
        rs2_data = rf_read(rs2);
    end

    // load in execute feeding this instruction
    assign stall = iss.ctrl.mem_read && iss.rd != '0 && (iss.rd == rs1 || iss.rd == rs2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss.ctrl <= rv_core_pkg::CTRL_BUBBLE;
            iss.rd   <= '0;
            iss.rs1  <= '0;
            iss.rs2  <= '0;
        end else begin
            iss.ctrl <= (stall || flush) ? rv_core_pkg::CTRL_BUBBLE : ctrl;
            iss.rd   <= rd;
            iss.rs1  <= rs1;
            iss.rs2  <= rs2;
        end
    end

    always_ff @(posedge clk) begin
        iss.pc       <= dec_pc;
        iss.imm      <= imm;
        iss.rs1_data <= rs1_data;
        iss.rs2_data <= rs2_data;
    end

    // a load in execute never redirects
    a_stall_flush: assert property (
        @(posedge clk) disable iff (rst) !(stall && flush)
    );

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    rv_issue_if.issue_dst                   iss,
    rv_fwd_if.fwd_exe                       fwd,
    output logic                            flush,
    output rv_core_pkg::word_t              target,
    output logic                            dm_we,
    output logic [rv_core_pkg::DMEM_AW-1:0] dm_addr,
    output rv_core_pkg::word_t              dm_wdata,
    output rv_core_pkg::word_t              res_value,
    output rv_core_pkg::reg_addr_t          res_rd,
    output logic                            res_reg_write,
    output logic                            res_mem_read
);

    rv_core_pkg::word_t rs1_val;
    rv_core_pkg::word_t rs2_val;
    rv_core_pkg::word_t op_a;
    rv_core_pkg::word_t op_b;
    rv_core_pkg::word_t alu_out;
    rv_core_pkg::word_t jump_base;
    rv_core_pkg::word_t jump_sum;
    logic               taken;

    // memory stage is younger, so it wins over writeback
    function automatic rv_core_pkg::word_t fwd_sel(
        input rv_core_pkg::reg_addr_t addr,
        input rv_core_pkg::word_t     issued
    );
        if (fwd.mem_reg_write && fwd.mem_rd == addr) return fwd.mem_value;
        if (fwd.wb_en && fwd.wb_rd == addr) return fwd.wb_data;
        return issued;
    endfunction

    always_comb begin
        rs1_val = fwd_sel(iss.rs1, iss.rs1_data);
        rs2_val = fwd_sel(iss.rs2, iss.rs2_data);
    end

    assign op_a = iss.ctrl.use_pc ? iss.pc : rs1_val;
    assign op_b = iss.ctrl.use_imm ? iss.imm : rs2_val;

    always_comb begin
        case (iss.ctrl.alu_op)
            rv_core_pkg::ALU_ADD:  alu_out = op_a + op_b;
            rv_core_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_core_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
            rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            rv_core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
            rv_core_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            rv_core_pkg::ALU_OR:   alu_out = op_a | op_b;
            rv_core_pkg::ALU_AND:  alu_out = op_a & op_b;
            rv_core_pkg::ALU_LUI:  alu_out = op_b;
            rv_core_pkg::ALU_LINK: alu_out = iss.pc + 32'd4;
            default:               alu_out = '0;
        endcase
    end

    always_comb begin
        case (iss.ctrl.alu_op)
            rv_core_pkg::ALU_BEQ:  taken = rs1_val == rs2_val;
            rv_core_pkg::ALU_BNE:  taken = rs1_val != rs2_val;
            rv_core_pkg::ALU_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
            rv_core_pkg::ALU_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
            rv_core_pkg::ALU_BLTU: taken = rs1_val < rs2_val;
            rv_core_pkg::ALU_BGEU: taken = rs1_val >= rs2_val;
            default:               taken = 1'b0;
        endcase
    end

    assign jump_base = iss.ctrl.jalr ? rs1_val : iss.pc;
    assign jump_sum  = jump_base + iss.imm;
    // jalr drops bit 0 of the sum
    assign target    = {jump_sum[rv_core_pkg::XLEN-1:1], 1'b0};
    assign flush     = iss.ctrl.jal || iss.ctrl.jalr || taken;

    assign dm_we    = iss.ctrl.mem_write;
    assign dm_addr  = alu_out[rv_core_pkg::DMEM_AW+1:2];
    assign dm_wdata = rs2_val;

    assign res_value     = alu_out;
    assign res_rd        = iss.rd;
    assign res_reg_write = iss.ctrl.reg_write;
    assign res_mem_read  = iss.ctrl.mem_read;

    a_mem_excl: assert property (
        @(posedge iss.clk) disable iff (iss.rst) !(dm_we && res_mem_read)
    );

endmodule

`default_nettype wire

// ==== rv_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_writeback (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_core_pkg::word_t     res_value,
    input  rv_core_pkg::reg_addr_t res_rd,
    input  logic                   res_reg_write,
    input  logic                   res_mem_read,
    input  rv_core_pkg::word_t     dm_rdata,
    rv_fwd_if.fwd_src              fwd
);

    logic               mem_read_m;
    logic               mem_read_w;
    rv_core_pkg::word_t value_w;
    rv_core_pkg::word_t load_w;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd.mem_rd        <= '0;
            fwd.mem_reg_write <= 1'b0;
            mem_read_m        <= 1'b0;
            fwd.wb_rd         <= '0;
            fwd.wb_en         <= 1'b0;
            mem_read_w        <= 1'b0;
        end else begin
            fwd.mem_rd        <= res_rd;
            fwd.mem_reg_write <= res_reg_write;
            mem_read_m        <= res_mem_read;
            fwd.wb_rd         <= fwd.mem_rd;
            fwd.wb_en         <= fwd.mem_reg_write;
            mem_read_w        <= mem_read_m;
        end
    end

    // load word arrives while the load sits in the memory stage
    always_ff @(posedge clk) begin
        fwd.mem_value <= res_value;
        value_w       <= fwd.mem_value;
        load_w        <= dm_rdata;
    end

    assign fwd.wb_data = mem_read_w ? load_w : value_w;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic                            clk,
    input  logic                            rst,
    output logic [rv_core_pkg::IMEM_AW-1:0] im_addr,
    input  rv_core_pkg::word_t              im_rdata,
    output logic                            dm_we,
    output logic [rv_core_pkg::DMEM_AW-1:0] dm_addr,
    output rv_core_pkg::word_t              dm_wdata,
    input  rv_core_pkg::word_t              dm_rdata
);

    logic                   stall;
    logic                   flush;
    rv_core_pkg::word_t     target;
    rv_core_pkg::word_t     dec_pc;
    rv_core_pkg::word_t     dec_insn;
    rv_core_pkg::word_t     res_value;
    rv_core_pkg::reg_addr_t res_rd;
    logic                   res_reg_write;
    logic                   res_mem_read;

    rv_issue_if i_issue_if (
        .clk (clk),
        .rst (rst)
    );

    rv_fwd_if i_fwd_if ();

    rv_fetch i_fetch (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .target   (target),
        .im_addr  (im_addr),
        .im_rdata (im_rdata),
        .dec_pc   (dec_pc),
        .dec_insn (dec_insn)
    );

    rv_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .dec_pc   (dec_pc),
        .dec_insn (dec_insn),
        .flush    (flush),
        .stall    (stall),
        .fwd      (i_fwd_if.fwd_dec),
        .iss      (i_issue_if.issue_src)
    );

    rv_execute i_execute (
        .iss           (i_issue_if.issue_dst),
        .fwd           (i_fwd_if.fwd_exe),
        .flush         (flush),
        .target        (target),
        .dm_we         (dm_we),
        .dm_addr       (dm_addr),
        .dm_wdata      (dm_wdata),
        .res_value     (res_value),
        .res_rd        (res_rd),
        .res_reg_write (res_reg_write),
        .res_mem_read  (res_mem_read)
    );

    rv_writeback i_writeback (
        .clk           (clk),
        .rst           (rst),
        .res_value     (res_value),
        .res_rd        (res_rd),
        .res_reg_write (res_reg_write),
        .res_mem_read  (res_mem_read),
        .dm_rdata      (dm_rdata),
        .fwd           (i_fwd_if.fwd_src)
    );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_HALF      = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 4;
    localparam int STORE_BASE    = 'hc0;
    localparam int STORE_TIMEOUT = 200;
    localparam int QUIET_CYCLES  = 100;
    localparam int IMEM_WORDS    = 2 ** rv_core_pkg::IMEM_AW;
    localparam int DMEM_WORDS    = 2 ** rv_core_pkg::DMEM_AW;

    logic                            clk;
    logic                            rst;
    logic [rv_core_pkg::IMEM_AW-1:0] im_addr;
    rv_core_pkg::word_t              im_rdata;
    logic                            dm_we;
    logic [rv_core_pkg::DMEM_AW-1:0] dm_addr;
    rv_core_pkg::word_t              dm_wdata;
    rv_core_pkg::word_t              dm_rdata;

    // dut outputs held from mid cycle
    logic [rv_core_pkg::IMEM_AW-1:0] im_addr_q;
    logic                            dm_we_q;
    logic [rv_core_pkg::DMEM_AW-1:0] dm_addr_q;
    rv_core_pkg::word_t              dm_wdata_q;

    rv_core_pkg::word_t imem [IMEM_WORDS];
    rv_core_pkg::word_t dmem [DMEM_WORDS];
    rv_core_pkg::word_t testdata [256];

    int value_errs;
    int timeout_errs;
    int extra_errs;
    int data_errs;

    rv_core i_rv_core (
        .clk      (clk),
        .rst      (rst),
        .im_addr  (im_addr),
        .im_rdata (im_rdata),
        .dm_we    (dm_we),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(negedge clk) begin
        im_addr_q  <= im_addr;
        dm_we_q    <= dm_we;
        dm_addr_q  <= dm_addr;
        dm_wdata_q <= dm_wdata;
    end

    // both memories answer one cycle after the address and read before write
    always @(posedge clk) begin
        #DRIVE_DLY;
        im_rdata = imem[im_addr_q];
        dm_rdata = dmem[dm_addr_q];
        if (dm_we_q) begin
            dmem[dm_addr_q] = dm_wdata_q;
        end
    end

    task automatic fill_memories;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            // addi x0 filler with immediate and rs1 taken from the address
            imem[i] = {i[11:0], 3'b000, i[13:12], 3'b000, 5'b00000, 7'b0010011};
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {2'b10, i[13:0], 2'b01, ~i[13:0]};
        end
    endtask

    task automatic load_program;
        for (int i = 0; i < STORE_BASE; i++) begin
            if (!$isunknown(testdata[i])) begin
                imem[i] = testdata[i];
            end
        end
    endtask

    task automatic compare_word(
        input string              name,
        input rv_core_pkg::word_t got,
        input rv_core_pkg::word_t exp
    );
        assert (got === exp) else begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic wait_for_store(input int idx, output bit found);
        int cycles;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            if (dm_we === 1'b1) begin
                found = 1'b1;
            end
            cycles++;
        end
        assert (found) else begin
            $display("timeout: store %0d did not appear within %0d cycles", idx, STORE_TIMEOUT);
            timeout_errs++;
        end
    endtask

    task automatic expect_no_stores;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (dm_we !== 1'b1) else begin
                $display("unexpected store to word %h after the last expected store", dm_addr);
                extra_errs++;
            end
        end
    endtask

    initial begin
        int n_stores;
        int k;
        bit found;
        bit aborted;
        rst        = 1'b1;
        im_rdata   = '0;
        dm_rdata   = '0;
        im_addr_q  = '0;
        dm_we_q    = 1'b0;
        dm_addr_q  = '0;
        dm_wdata_q = '0;
        value_errs   = 0;
        timeout_errs = 0;
        extra_errs   = 0;
        data_errs    = 0;
        n_stores     = 0;
        aborted      = 1'b0;

        fill_memories();
        $readmemh("rv_core_testdata.txt", testdata);
        load_program();
        assert (!$isunknown(testdata[STORE_BASE])) else begin
            $display("store list missing from rv_core_testdata.txt");
            data_errs++;
        end
        if (data_errs == 0) begin
            n_stores = testdata[STORE_BASE];
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
        rst = 1'b0;

        // first cycle out of reset fetches word 0 and stores nothing
        @(negedge clk);
        compare_word("im_addr", rv_core_pkg::word_t'(im_addr), '0);
        compare_word("dm_we", rv_core_pkg::word_t'(dm_we), '0);

        for (k = 0; k < n_stores; k++) begin
            if (!aborted) begin
                wait_for_store(k, found);
                if (found) begin
                    compare_word("dm_addr", rv_core_pkg::word_t'(dm_addr),
                                 testdata[STORE_BASE + 1 + 2 * k]);
                    compare_word("dm_wdata", dm_wdata, testdata[STORE_BASE + 2 + 2 * k]);
                end else begin
                    aborted = 1'b1;
                end
            end
        end
        if (!aborted) begin
            expect_no_stores();
        end

        $display("errors: %0d value, %0d timeout, %0d unexpected store, %0d data file",
                 value_errs, timeout_errs, extra_errs, data_errs);
        if (value_errs + timeout_errs + extra_errs + data_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core_testdata.txt ====
// @000: program words from byte address 0, four per line
// @0c0: store count, then one expected store per line as word address and data
@000
// alu register forms
00500093 FFD00113 002081B3 10302023
40208233 001122B3 00113333 0020C3B3
10402223 10502423 10602623 10702823
00109433 001154B3 40515533 001465B3
0083F633 10802A23 10902C23 10A02E23
12B02023 12C02223
// immediate forms, lui, auipc
FFE12693 7F06C713
01C15793 12345837 67886893 00001917
12E02423 12F02623 13102823 13202A23
// dependent chain, then load-use
00100993 013989B3 013989B3 01398A33
13402C23 013A0AB3 13502E23 11802B03
15602023 12002B83 001B8C13 15802223
// branches with stores in their shadow
00208463 14102423 00114463 14002623
00116463 14202823 00209663 14002A23
14002C23 0020D463 14002E23 0020F463
// jal, jalr, then halt loop
16302023 00C00CEF 16002223 16002423
17902623 0F900D13 00CD0DE7 16002823
16002A23 17B02C23 0000006F
@0c0
00000017
00000040 00000002
00000041 00000008
00000042 00000001
00000043 00000000
00000044 FFFFFFF8
00000045 000000A0
00000046 07FFFFFF
00000047 FFFFFFFE
00000048 000000A5
00000049 000000A0
0000004A 000007F1
0000004B 0000000F
0000004C 12345678
0000004D 0000106C
0000004E 00000008
0000004F 0000000C
00000050 07FFFFFF
00000051 000000A6
00000052 00000005
00000054 FFFFFFFD
00000058 00000002
0000005B 000000E8
0000005E 000000FC

// ==== rv_core.f ====
rv_core_pkg.sv
rv_core_if.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_core_if.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_writeback.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
